// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fu_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ns

// one ALU unit: operand mux, ALU and branch condition
module alu_unit (
    fu_issue_if.unit           issue,
    input  fu_pkg::alu_func_e  func,
    input  logic               cond_branch,
    input  logic               uncond_branch,
    output fu_pkg::data_t      result,
    output logic               take_branch
);

    fu_pkg::data_t                  opa;
    fu_pkg::data_t                  opb;
    logic signed [fu_pkg::XLEN-1:0] rs1_s;
    logic signed [fu_pkg::XLEN-1:0] rs2_s;
    logic        [2:0]              funct3;
    logic                           cond_true;

    operand_select u_opsel (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    int_alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (result) // also the branch target
    );

    // compare works on raw register values, not the muxed operands
    assign rs1_s  = issue.op1;
    assign rs2_s  = issue.op2;
    assign funct3 = issue.inst[14:12];

    always_comb begin
        case (funct3)
            fu_pkg::F3_BEQ:  cond_true = (rs1_s == rs2_s);
            fu_pkg::F3_BNE:  cond_true = (rs1_s != rs2_s);
            fu_pkg::F3_BLT:  cond_true = (rs1_s <  rs2_s);
            fu_pkg::F3_BGE:  cond_true = (rs1_s >= rs2_s);
            fu_pkg::F3_BLTU: cond_true = (issue.op1 <  issue.op2);
            fu_pkg::F3_BGEU: cond_true = (issue.op1 >= issue.op2);
            default:         cond_true = 1'b0; // 010 and 011 are not branches
        endcase
    end

    // jumps always redirect
    assign take_branch = uncond_branch || (cond_branch && cond_true);

endmodule

// ==== rtl/fu_issue_if.sv ====
`timescale 1ns/1ns

// operand group handed from the issue stage to one unit
interface fu_issue_if;

    logic             valid;
    fu_pkg::inst_t    inst;
    fu_pkg::addr_t    pc;
    fu_pkg::data_t    op1;   // rs1 value
    fu_pkg::data_t    op2;   // rs2 value
    fu_pkg::opa_sel_e opa_sel;
    fu_pkg::opb_sel_e opb_sel;

    modport issuer (
        output valid, inst, pc, op1, op2, opa_sel, opb_sel
    );

    modport unit (
        input valid, inst, pc, op1, op2, opa_sel, opb_sel
    );

endinterface

// ==== rtl/fu_pkg.sv ====
package fu_pkg;

    // datapath widths
    localparam int XLEN   = 32;
    localparam int PRN_W  = 6;
    localparam int ROBN_W = 5;

    // unit counts
    localparam int NUM_ALU  = 2;
    localparam int NUM_MULT = 1;

    // multiplier depth, must divide the 64-bit product width
    localparam int MULT_STAGES  = 4;
    localparam int MULT_SLICE_W = (2 * XLEN) / MULT_STAGES; // multiplier bits per stage

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [31:0]       inst_t;
    typedef logic [PRN_W-1:0]  prn_t;
    typedef logic [ROBN_W-1:0] robn_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SRL  = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    typedef enum logic [1:0] {
        MULT_MUL    = 2'h0,
        MULT_MULH   = 2'h1,
        MULT_MULHSU = 2'h2,
        MULT_MULHU  = 2'h3
    } mult_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    // branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // marker words for undefined selects and functions
    localparam data_t OPA_MARKER = 32'hdeadface;
    localparam data_t OPB_MARKER = 32'hfacefeed;
    localparam data_t ALU_MARKER = 32'hfacebeec;

endpackage

// ==== rtl/fu_top.sv ====
`timescale 1ns/1ns

// integer execute block: ALU units plus one pipelined multiplier
module fu_top (
    input  logic                                        clock,
    input  logic                                        rst_n,
    input  logic                                        squash,
    input  logic               [fu_pkg::NUM_ALU-1:0]    alu_valid,
    input  logic               [fu_pkg::NUM_ALU-1:0]    alu_cond_branch,
    input  logic               [fu_pkg::NUM_ALU-1:0]    alu_uncond_branch,
    input  fu_pkg::inst_t      [fu_pkg::NUM_ALU-1:0]    alu_inst,
    input  fu_pkg::addr_t      [fu_pkg::NUM_ALU-1:0]    alu_pc,
    input  fu_pkg::data_t      [fu_pkg::NUM_ALU-1:0]    alu_op1,
    input  fu_pkg::data_t      [fu_pkg::NUM_ALU-1:0]    alu_op2,
    input  fu_pkg::alu_func_e  [fu_pkg::NUM_ALU-1:0]    alu_func,
    input  fu_pkg::opa_sel_e   [fu_pkg::NUM_ALU-1:0]    alu_opa_sel,
    input  fu_pkg::opb_sel_e   [fu_pkg::NUM_ALU-1:0]    alu_opb_sel,
    input  fu_pkg::prn_t       [fu_pkg::NUM_ALU-1:0]    alu_dest_prn,
    input  fu_pkg::robn_t      [fu_pkg::NUM_ALU-1:0]    alu_robn,
    input  logic                                        mult_valid,
    input  logic                                        mult_avail,
    input  fu_pkg::inst_t                               mult_inst,
    input  fu_pkg::addr_t                               mult_pc,
    input  fu_pkg::data_t                               mult_op1,
    input  fu_pkg::data_t                               mult_op2,
    input  fu_pkg::opa_sel_e                            mult_opa_sel,
    input  fu_pkg::opb_sel_e                            mult_opb_sel,
    input  fu_pkg::prn_t                                mult_dest_prn,
    input  fu_pkg::robn_t                               mult_robn,
    input  fu_pkg::mult_func_e                          mult_func,
    output logic               [fu_pkg::NUM_ALU-1:0]    alu_wb_valid,
    output fu_pkg::data_t      [fu_pkg::NUM_ALU-1:0]    alu_wb_result,
    output fu_pkg::prn_t       [fu_pkg::NUM_ALU-1:0]    alu_wb_prn,
    output fu_pkg::robn_t      [fu_pkg::NUM_ALU-1:0]    alu_wb_robn,
    output logic               [fu_pkg::NUM_ALU-1:0]    rob_branch_executed,
    output logic               [fu_pkg::NUM_ALU-1:0]    rob_branch_taken,
    output fu_pkg::addr_t      [fu_pkg::NUM_ALU-1:0]    rob_branch_target,
    output fu_pkg::robn_t      [fu_pkg::NUM_ALU-1:0]    rob_branch_robn,
    output logic                                        mult_wb_valid,
    output fu_pkg::data_t                               mult_wb_result,
    output fu_pkg::prn_t                                mult_wb_prn,
    output fu_pkg::robn_t                               mult_wb_robn
);

    fu_pkg::data_t [fu_pkg::NUM_ALU-1:0] alu_result;
    logic          [fu_pkg::NUM_ALU-1:0] alu_take;
    logic                                mult_clear;

    assign mult_clear = !rst_n || squash; // flush on reset or mispredict

    for (genvar i = 0; i < fu_pkg::NUM_ALU; i++) begin : g_alu
        fu_issue_if alu_issue ();

        assign alu_issue.valid   = alu_valid[i];
        assign alu_issue.inst    = alu_inst[i];
        assign alu_issue.pc      = alu_pc[i];
        assign alu_issue.op1     = alu_op1[i];
        assign alu_issue.op2     = alu_op2[i];
        assign alu_issue.opa_sel = alu_opa_sel[i];
        assign alu_issue.opb_sel = alu_opb_sel[i];

        alu_unit u_alu (
            .issue         (alu_issue),
            .func          (alu_func[i]),
            .cond_branch   (alu_cond_branch[i]),
            .uncond_branch (alu_uncond_branch[i]),
            .result        (alu_result[i]),
            .take_branch   (alu_take[i])
        );

        // single cycle, no avail handshake
        assign alu_wb_valid[i]        = alu_valid[i];
        assign alu_wb_result[i]       = alu_result[i];
        assign alu_wb_prn[i]          = alu_dest_prn[i];
        assign alu_wb_robn[i]         = alu_robn[i];

        assign rob_branch_executed[i] = alu_valid[i] && alu_cond_branch[i];
        assign rob_branch_taken[i]    = alu_take[i];
        assign rob_branch_target[i]   = alu_result[i]; // target computed by the ALU
        assign rob_branch_robn[i]     = alu_robn[i];
    end

    // top-level multiplier ports are scalar, one unit
    for (genvar m = 0; m < fu_pkg::NUM_MULT; m++) begin : g_mult
        fu_issue_if mult_issue ();

        assign mult_issue.valid   = mult_valid;
        assign mult_issue.inst    = mult_inst;
        assign mult_issue.pc      = mult_pc;
        assign mult_issue.op1     = mult_op1;
        assign mult_issue.op2     = mult_op2;
        assign mult_issue.opa_sel = mult_opa_sel;
        assign mult_issue.opb_sel = mult_opb_sel;

        mult_unit u_mult (
            .clock     (clock),
            .rst_n     (rst_n),
            .clear     (mult_clear),
            .avail     (mult_avail),
            .issue     (mult_issue),
            .func      (mult_func),
            .dest_prn  (mult_dest_prn),
            .robn      (mult_robn),
            .done      (mult_wb_valid),
            .result    (mult_wb_result),
            .done_prn  (mult_wb_prn),
            .done_robn (mult_wb_robn)
        );
    end

endmodule

// ==== rtl/int_alu.sv ====
`timescale 1ns/1ns

// single-cycle integer ALU, purely combinational
module int_alu (
    input  fu_pkg::data_t     opa,
    input  fu_pkg::data_t     opb,
    input  fu_pkg::alu_func_e func,
    output fu_pkg::data_t     result
);

    logic signed [fu_pkg::XLEN-1:0] opa_s;
    logic signed [fu_pkg::XLEN-1:0] opb_s;
    logic        [4:0]              shamt;

    assign opa_s = opa;
    assign opb_s = opb;
    assign shamt = opb[4:0]; // RV32 shifts use the low 5 bits only

    always_comb begin
        case (func)
            fu_pkg::ALU_ADD:  result = opa + opb;
            fu_pkg::ALU_SUB:  result = opa - opb;
            fu_pkg::ALU_AND:  result = opa & opb;
            fu_pkg::ALU_OR:   result = opa | opb;
            fu_pkg::ALU_XOR:  result = opa ^ opb;
            fu_pkg::ALU_SLT:  result = fu_pkg::data_t'(opa_s < opb_s);
            fu_pkg::ALU_SLTU: result = fu_pkg::data_t'(opa < opb);
            fu_pkg::ALU_SRL:  result = opa >> shamt;
            fu_pkg::ALU_SLL:  result = opa << shamt;
            fu_pkg::ALU_SRA:  result = fu_pkg::data_t'(opa_s >>> shamt); // sign fill
            default:          result = fu_pkg::ALU_MARKER;
        endcase
    end

endmodule

// ==== rtl/mult_unit.sv ====
`timescale 1ns/1ns

// pipelined multiplier, one multiplier slice per stage
module mult_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               avail,
    fu_issue_if.unit           issue,
    input  fu_pkg::mult_func_e func,
    input  fu_pkg::prn_t       dest_prn,
    input  fu_pkg::robn_t      robn,
    output logic               done,
    output fu_pkg::data_t      result,
    output fu_pkg::prn_t       done_prn,
    output fu_pkg::robn_t      done_robn
);

    localparam int S  = fu_pkg::MULT_STAGES;
    localparam int SW = fu_pkg::MULT_SLICE_W;
    localparam int W  = 2 * fu_pkg::XLEN;

    fu_pkg::data_t opa;
    fu_pkg::data_t opb;
    logic          a_signed;
    logic          b_signed;

    // stage registers
    logic               stg_valid  [S];
    logic [W-1:0]       stg_acc    [S];
    logic [W-1:0]       stg_mcand  [S];
    logic [W-1:0]       stg_mplier [S];
    fu_pkg::mult_func_e stg_func   [S];
    fu_pkg::prn_t       stg_prn    [S];
    fu_pkg::robn_t      stg_robn   [S];

    // inputs seen by each stage
    logic               in_valid   [S];
    logic [W-1:0]       in_acc     [S];
    logic [W-1:0]       in_mcand   [S];
    logic [W-1:0]       in_mplier  [S];
    fu_pkg::mult_func_e in_func    [S];
    fu_pkg::prn_t       in_prn     [S];
    fu_pkg::robn_t      in_robn    [S];

    operand_select u_opsel (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    // MUL keeps only the low word, so signedness does not matter there
    assign a_signed = (func == fu_pkg::MULT_MULH) || (func == fu_pkg::MULT_MULHSU);
    assign b_signed = (func == fu_pkg::MULT_MULH);

    always_comb begin
        in_valid[0]  = issue.valid;
        in_acc[0]    = '0;
        in_mcand[0]  = {{fu_pkg::XLEN{a_signed & opa[fu_pkg::XLEN-1]}}, opa};
        in_mplier[0] = {{fu_pkg::XLEN{b_signed & opb[fu_pkg::XLEN-1]}}, opb};
        in_func[0]   = func;
        in_prn[0]    = dest_prn;
        in_robn[0]   = robn;
        for (int k = 1; k < S; k++) begin
            in_valid[k]  = stg_valid[k-1];
            in_acc[k]    = stg_acc[k-1];
            in_mcand[k]  = stg_mcand[k-1];
            in_mplier[k] = stg_mplier[k-1];
            in_func[k]   = stg_func[k-1];
            in_prn[k]    = stg_prn[k-1];
            in_robn[k]   = stg_robn[k-1];
        end
    end

    // valids only, squash flushes everything in flight
    always_ff @(posedge clock) begin
        if (!rst_n || clear) begin
            for (int k = 0; k < S; k++) begin
                stg_valid[k] <= 1'b0;
            end
        end else if (avail) begin
            for (int k = 0; k < S; k++) begin
                stg_valid[k] <= in_valid[k];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (avail) begin // whole pipe holds while writeback is busy
            for (int k = 0; k < S; k++) begin
                stg_acc[k]    <= in_acc[k] + in_mcand[k] * W'(in_mplier[k][SW-1:0]);
                stg_mcand[k]  <= in_mcand[k] << SW;  // line up with next slice
                stg_mplier[k] <= in_mplier[k] >> SW;
                stg_func[k]   <= in_func[k];
                stg_prn[k]    <= in_prn[k];
                stg_robn[k]   <= in_robn[k];
            end
        end
    end

    assign done      = stg_valid[S-1];
    assign done_prn  = stg_prn[S-1];
    assign done_robn = stg_robn[S-1];
    assign result    = (stg_func[S-1] == fu_pkg::MULT_MUL) ? stg_acc[S-1][fu_pkg::XLEN-1:0]
                                                           : stg_acc[S-1][W-1:fu_pkg::XLEN];

endmodule

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ns

module operand_select (
    fu_issue_if.unit       issue,
    output fu_pkg::data_t  opa,
    output fu_pkg::data_t  opb
);

    fu_pkg::data_t i_imm;
    fu_pkg::data_t s_imm;
    fu_pkg::data_t b_imm;
    fu_pkg::data_t u_imm;
    fu_pkg::data_t j_imm;

    // RV32 immediate formats, all sign extended from inst[31]
    assign i_imm = {{20{issue.inst[31]}}, issue.inst[31:20]};
    assign s_imm = {{20{issue.inst[31]}}, issue.inst[31:25], issue.inst[11:7]};
    assign b_imm = {{19{issue.inst[31]}}, issue.inst[31], issue.inst[7],
                    issue.inst[30:25], issue.inst[11:8], 1'b0};
    assign u_imm = {issue.inst[31:12], 12'b0};
    assign j_imm = {{11{issue.inst[31]}}, issue.inst[31], issue.inst[19:12],
                    issue.inst[20], issue.inst[30:21], 1'b0};

    // opa mux
    always_comb begin
        case (issue.opa_sel)
            fu_pkg::OPA_IS_RS1:  opa = issue.op1;
            fu_pkg::OPA_IS_PC:   opa = issue.pc;
            fu_pkg::OPA_IS_ZERO: opa = '0;
            default:             opa = fu_pkg::OPA_MARKER; // select code 3 unused
        endcase
    end

    // opb mux
    always_comb begin
        case (issue.opb_sel)
            fu_pkg::OPB_IS_RS2:   opb = issue.op2;
            fu_pkg::OPB_IS_I_IMM: opb = i_imm;
            fu_pkg::OPB_IS_S_IMM: opb = s_imm;
            fu_pkg::OPB_IS_B_IMM: opb = b_imm;
            fu_pkg::OPB_IS_U_IMM: opb = u_imm;
            fu_pkg::OPB_IS_J_IMM: opb = j_imm;
            default:              opb = fu_pkg::OPB_MARKER;
        endcase
    end

endmodule

// ==== verif/fu_tb.sv ====
`timescale 1ns/1ns

module fu_tb;

    localparam int TIMEOUT_CYCLES = 5000; // tests run about 2200 cycles
    localparam int NA = fu_pkg::NUM_ALU;

    typedef struct packed {
        logic [31:0] result;
        logic [5:0]  prn;
        logic [4:0]  robn;
        logic [31:0] due;   // accepting-edge count at writeback
    } mult_exp_t;

    logic clock;
    logic rst_n;
    logic squash;
    logic [NA-1:0] alu_valid, alu_cond_branch, alu_uncond_branch;
    fu_pkg::inst_t      [NA-1:0] alu_inst;
    fu_pkg::addr_t      [NA-1:0] alu_pc;
    fu_pkg::data_t      [NA-1:0] alu_op1, alu_op2;
    fu_pkg::alu_func_e  [NA-1:0] alu_func;
    fu_pkg::opa_sel_e   [NA-1:0] alu_opa_sel;
    fu_pkg::opb_sel_e   [NA-1:0] alu_opb_sel;
    fu_pkg::prn_t       [NA-1:0] alu_dest_prn;
    fu_pkg::robn_t      [NA-1:0] alu_robn;
    logic mult_valid, mult_avail;
    fu_pkg::inst_t      mult_inst;
    fu_pkg::addr_t      mult_pc;
    fu_pkg::data_t      mult_op1, mult_op2;
    fu_pkg::opa_sel_e   mult_opa_sel;
    fu_pkg::opb_sel_e   mult_opb_sel;
    fu_pkg::prn_t       mult_dest_prn;
    fu_pkg::robn_t      mult_robn;
    fu_pkg::mult_func_e mult_func;
    logic          [NA-1:0] alu_wb_valid, rob_branch_executed, rob_branch_taken;
    fu_pkg::data_t [NA-1:0] alu_wb_result;
    fu_pkg::prn_t  [NA-1:0] alu_wb_prn;
    fu_pkg::robn_t [NA-1:0] alu_wb_robn, rob_branch_robn;
    fu_pkg::addr_t [NA-1:0] rob_branch_target;
    logic          mult_wb_valid;
    fu_pkg::data_t mult_wb_result;
    fu_pkg::prn_t  mult_wb_prn;
    fu_pkg::robn_t mult_wb_robn;

    int          seed = 94206;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int unsigned acc_edges = 0;
    mult_exp_t   exp_q[$];
    bit          after_clear = 1'b1;
    bit          stalled_last = 1'b0;
    logic        held_valid;
    logic [31:0] held_result;
    logic [31:0] held_prn;
    logic [31:0] held_robn;

    fu_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic fu_pkg::data_t pick_operand();
        int r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h8000_0000; // most negative
            default: return $random(seed);
        endcase
    endfunction

    function automatic fu_pkg::data_t alu_ref(input fu_pkg::alu_func_e f,
                                              input fu_pkg::data_t a, input fu_pkg::data_t b);
        case (f)
            fu_pkg::ALU_ADD:  return a + b;
            fu_pkg::ALU_SUB:  return a - b;
            fu_pkg::ALU_AND:  return a & b;
            fu_pkg::ALU_OR:   return a | b;
            fu_pkg::ALU_XOR:  return a ^ b;
            fu_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            fu_pkg::ALU_SLTU: return {31'b0, a < b};
            fu_pkg::ALU_SRL:  return a >> b[4:0];
            fu_pkg::ALU_SLL:  return a << b[4:0];
            fu_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            default:          return 32'hx;
        endcase
    endfunction

    // rs2 or a sign-extended RV32 immediate
    function automatic fu_pkg::data_t opb_ref(input fu_pkg::opb_sel_e sel,
                                              input fu_pkg::data_t rs2, input fu_pkg::inst_t i);
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [20:0] imm21;
        imm12 = (sel == fu_pkg::OPB_IS_S_IMM) ? {i[31:25], i[11:7]} : i[31:20];
        imm13 = {i[31], i[7], i[30:25], i[11:8], 1'b0};
        imm21 = {i[31], i[19:12], i[20], i[30:21], 1'b0};
        case (sel)
            fu_pkg::OPB_IS_I_IMM, fu_pkg::OPB_IS_S_IMM: return 32'($signed(imm12));
            fu_pkg::OPB_IS_B_IMM: return 32'($signed(imm13));
            fu_pkg::OPB_IS_U_IMM: return {i[31:12], 12'h000};
            fu_pkg::OPB_IS_J_IMM: return 32'($signed(imm21));
            default:              return rs2;
        endcase
    endfunction

    function automatic bit branch_ref(input logic [2:0] f3, input fu_pkg::data_t a,
                                      input fu_pkg::data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return !($signed(a) < $signed(b));
            3'b110:  return a < b;
            3'b111:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic fu_pkg::data_t mult_ref(input fu_pkg::mult_func_e f,
                                               input fu_pkg::data_t a, input fu_pkg::data_t b);
        longint      sa;
        longint      sb;
        logic [63:0] p;
        sa = $signed(a);
        sb = $signed(b);
        case (f)
            fu_pkg::MULT_MULHSU: p = sa * longint'({32'b0, b});
            fu_pkg::MULT_MULHU:  p = {32'b0, a} * {32'b0, b};
            default:             p = sa * sb;
        endcase
        return (f == fu_pkg::MULT_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic check_alu_unit(input int u);
        fu_pkg::data_t a;
        fu_pkg::data_t exp;
        bit            take;
        case (alu_opa_sel[u])
            fu_pkg::OPA_IS_PC:   a = alu_pc[u];
            fu_pkg::OPA_IS_ZERO: a = '0;
            default:             a = alu_op1[u];
        endcase
        exp  = alu_ref(alu_func[u], a, opb_ref(alu_opb_sel[u], alu_op2[u], alu_inst[u]));
        take = alu_uncond_branch[u] ||
               (alu_cond_branch[u] && branch_ref(alu_inst[u][14:12], alu_op1[u], alu_op2[u]));
        check_value($sformatf("alu_wb_result[%0d]", u), exp, alu_wb_result[u]);
        check_value($sformatf("alu_wb_prn[%0d]", u), 32'(alu_dest_prn[u]), 32'(alu_wb_prn[u]));
        check_value($sformatf("alu_wb_robn[%0d]", u), 32'(alu_robn[u]), 32'(alu_wb_robn[u]));
        check_value($sformatf("rob_branch_taken[%0d]", u), 32'(take),
                    32'(rob_branch_taken[u]));
        check_value($sformatf("rob_branch_target[%0d]", u), exp, rob_branch_target[u]);
        check_value($sformatf("rob_branch_robn[%0d]", u), 32'(alu_robn[u]),
                    32'(rob_branch_robn[u]));
    endtask

    // mode 0 register operands, 1 random selects with ADD, 2 branches
    task automatic run_alu_cycle(input int mode, input int f);
        int unsigned r;
        @(posedge clock);
        #1;
        for (int u = 0; u < NA; u++) begin
            r = $random(seed);
            alu_valid[u]         = r[20];
            alu_inst[u]          = $random(seed);
            alu_pc[u]            = $random(seed);
            alu_op1[u]           = pick_operand();
            alu_op2[u]           = pick_operand();
            alu_dest_prn[u]      = fu_pkg::prn_t'(r >> 4);
            alu_robn[u]          = fu_pkg::robn_t'(r >> 12);
            alu_cond_branch[u]   = 1'b0;
            alu_uncond_branch[u] = 1'b0;
            alu_opa_sel[u]       = fu_pkg::OPA_IS_RS1;
            alu_opb_sel[u]       = fu_pkg::OPB_IS_RS2;
            alu_func[u]          = fu_pkg::alu_func_e'(f);
            if (mode == 1) begin
                alu_opa_sel[u] = fu_pkg::opa_sel_e'(r % 3);
                alu_opb_sel[u] = fu_pkg::opb_sel_e'((r / 3) % 6);
            end else if (mode == 2) begin
                alu_cond_branch[u]   = (r % 3 == 0);
                alu_uncond_branch[u] = (r % 3 == 1);
                alu_opa_sel[u]       = fu_pkg::OPA_IS_PC;
                alu_opb_sel[u]       = alu_cond_branch[u] ? fu_pkg::OPB_IS_B_IMM
                                                          : fu_pkg::OPB_IS_J_IMM;
                if (r[8]) begin
                    alu_op2[u] = alu_op1[u]; // equal operands for BEQ and BGE
                end
            end
        end
        #1;
        for (int u = 0; u < NA; u++) begin
            check_alu_unit(u);
        end
    endtask

    task automatic mult_cycle(input bit issue, input bit avail, input bit flush);
        int unsigned r;
        @(posedge clock);
        #1;
        r             = $random(seed);
        squash        = flush;
        mult_avail    = avail;
        mult_valid    = issue && avail; // never presented while stalled
        mult_func     = fu_pkg::mult_func_e'(r % 4);
        mult_op1      = pick_operand();
        mult_op2      = pick_operand();
        mult_dest_prn = fu_pkg::prn_t'(r >> 4);
        mult_robn     = fu_pkg::robn_t'(r >> 12);
        mult_inst     = $random(seed);
        mult_pc       = $random(seed);
    endtask

    // multiplier scoreboard, sampled on the edge
    always @(posedge clock) begin
        mult_exp_t head;
        if (!rst_n || squash) begin
            exp_q.delete(); // in-flight products are dropped
        end else begin
            if (after_clear) begin
                check_value("mult_wb_valid", 32'(1'b0), 32'(mult_wb_valid));
            end
            if (stalled_last) begin
                check_value("mult_wb_valid", 32'(held_valid), 32'(mult_wb_valid));
                check_value("mult_wb_result", held_result, mult_wb_result);
                check_value("mult_wb_prn", held_prn, 32'(mult_wb_prn));
                check_value("mult_wb_robn", held_robn, 32'(mult_wb_robn));
            end
            if (mult_avail) begin
                if (mult_wb_valid && exp_q.size() == 0) begin
                    $display("multiplier wrote back a result with no product in flight");
                    errors++;
                end else if (mult_wb_valid) begin
                    head = exp_q.pop_front();
                    check_value("mult_wb_result", head.result, mult_wb_result);
                    check_value("mult_wb_prn", 32'(head.prn), 32'(mult_wb_prn));
                    check_value("mult_wb_robn", 32'(head.robn), 32'(mult_wb_robn));
                    check_value("mult latency", head.due, acc_edges);
                end else if (exp_q.size() != 0 && exp_q[0].due == acc_edges) begin
                    $display("multiplier result due at time %0t did not appear", $time);
                    errors++;
                end
                if (mult_valid) begin
                    exp_q.push_back({mult_ref(mult_func, mult_op1, mult_op2),
                                     mult_dest_prn, mult_robn,
                                     acc_edges + fu_pkg::MULT_STAGES});
                end
                acc_edges++;
            end
        end
        after_clear  = !rst_n || squash;
        stalled_last = rst_n && !squash && !mult_avail;
        held_valid   = mult_wb_valid;
        held_result  = mult_wb_result;
        held_prn     = 32'(mult_wb_prn);
        held_robn    = 32'(mult_wb_robn);
    end

    assert property (@(posedge clock) rob_branch_executed == (alu_valid & alu_cond_branch))
        else begin
            $display("CHECK FAILED time=%0t signal=rob_branch_executed expected=%b actual=%b",
                     $time, alu_valid & alu_cond_branch, rob_branch_executed);
            errors++;
        end

    assert property (@(posedge clock) alu_wb_valid == alu_valid)
        else begin
            $display("CHECK FAILED time=%0t signal=alu_wb_valid expected=%b actual=%b",
                     $time, alu_valid, alu_wb_valid);
            errors++;
        end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("checks: %0d  errors: %0d", checks, errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int stall_left;
        rst_n  = 1'b0;
        squash = 1'b0;
        for (int u = 0; u < NA; u++) begin
            alu_valid[u]         = 1'b0;
            alu_cond_branch[u]   = 1'b0;
            alu_uncond_branch[u] = 1'b0;
            alu_inst[u]          = '0;
            alu_pc[u]            = '0;
            alu_op1[u]           = '0;
            alu_op2[u]           = '0;
            alu_func[u]          = fu_pkg::ALU_ADD;
            alu_opa_sel[u]       = fu_pkg::OPA_IS_RS1;
            alu_opb_sel[u]       = fu_pkg::OPB_IS_RS2;
            alu_dest_prn[u]      = '0;
            alu_robn[u]          = '0;
        end
        mult_valid    = 1'b0;
        mult_avail    = 1'b1;
        mult_inst     = '0;
        mult_pc       = '0;
        mult_op1      = '0;
        mult_op2      = '0;
        mult_opa_sel  = fu_pkg::OPA_IS_RS1;
        mult_opb_sel  = fu_pkg::OPB_IS_RS2;
        mult_dest_prn = '0;
        mult_robn     = '0;
        mult_func     = fu_pkg::MULT_MUL;
        stall_left    = 0;
        repeat (10) @(posedge clock);
        #1 rst_n = 1'b1;

        for (int f = 0; f < 10; f++) begin
            repeat (20) run_alu_cycle(0, f);
        end
        repeat (300) run_alu_cycle(1, 0);
        repeat (300) run_alu_cycle(2, 0);

        repeat (400) mult_cycle(1'b1, 1'b1, 1'b0); // back to back
        for (int n = 0; n < 600; n++) begin
            if (stall_left > 0) begin
                stall_left--;
                mult_cycle(1'b0, 1'b0, 1'b0);
            end else begin
                if ($random(seed) % 4 == 0) begin
                    stall_left = 1 + ($unsigned($random(seed)) % 8);
                end
                mult_cycle($random(seed) % 4 != 0, 1'b1, 1'b0);
            end
        end
        while (exp_q.size() != 0) begin
            mult_cycle(1'b0, 1'b1, 1'b0);
        end

        for (int n = 0; n < 20; n++) begin
            repeat (1 + ($unsigned($random(seed)) % 6)) mult_cycle(1'b1, 1'b1, 1'b0);
            mult_cycle(1'b1, 1'b1, 1'b1); // squash with an issue presented
            mult_cycle(n % 2 == 0, 1'b1, 1'b0);
            repeat (fu_pkg::MULT_STAGES + 1) mult_cycle(1'b0, 1'b1, 1'b0);
        end
        mult_cycle(1'b0, 1'b1, 1'b0);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/fu_pkg.sv
rtl/fu_issue_if.sv
rtl/operand_select.sv
rtl/int_alu.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/fu_top.sv
verif/fu_tb.sv
